//--- filelist.f
design/core_pkg.sv
design/decode.sv
design/dispatch.sv
design/alu_execute.sv
design/rob.sv
design/core_top.sv
verif/core_tb.sv

//--- Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -Wno-fatal
TOP       ?= core_tb
FILELIST  ?= filelist.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
PASS_MSG  := Done: no errors

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: compile
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- verif/core_tb.sv
`timescale 1ns/1ps

module core_tb import core_pkg::*; ();

    localparam int ACCEPT_LIMIT = 100; // cycles a word may wait for instr_ready
    localparam int STALL_LIMIT  = 20;  // wait that counts as a stall under back-pressure
    localparam int DRAIN_LIMIT  = 300;

    logic    clk = 1'b0;
    logic    reset;
    logic    instr_valid;
    logic    instr_ready;
    instr_t  instr;
    logic    commit_valid;
    logic    commit_ready;
    commit_t commit;

    reg_data_t ref_regs [32];     // architectural state in program order
    commit_t   expected_q [$];
    int        errors = 0;
    int        checks = 0;

    core_top uut (
        .clk          (clk),
        .reset        (reset),
        .instr_valid  (instr_valid),
        .instr_ready  (instr_ready),
        .instr        (instr),
        .commit_valid (commit_valid),
        .commit_ready (commit_ready),
        .commit       (commit)
    );

    always #5 clk = ~clk;

    task automatic compare(input string what, input logic [31:0] got, input logic [31:0] want);
        checks++;
        if (got !== want) begin
            errors++;
            $display("Fail at %0t: %s got %h expected %h", $time, what, got, want);
        end
    endtask

    task automatic finish_run();
        $display("%0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    endtask

    task automatic abort_timeout(input string why);
        errors++;
        $display("timeout at %0t: %s", $time, why);
        finish_run();
    endtask

    function automatic instr_t r_type_word(input logic [6:0] f7, input arf_id_t rs2,
                                           input arf_id_t rs1, input logic [2:0] f3,
                                           input arf_id_t rd);
        return {f7, rs2, rs1, f3, rd, 7'b0110011};
    endfunction

    function automatic instr_t i_type_word(input logic [11:0] imm, input arf_id_t rs1,
                                           input logic [2:0] f3, input arf_id_t rd);
        return {imm, rs1, f3, rd, 7'b0010011};
    endfunction

    function automatic instr_t lui_word(input logic [19:0] imm, input arf_id_t rd);
        return {imm, rd, 7'b0110111};
    endfunction

    function automatic bit is_legal(input instr_t w);
        return w[6:0] == 7'b0110011 || w[6:0] == 7'b0010011 || w[6:0] == 7'b0110111;
    endfunction

    // RV32I semantics computed against the reference registers
    function automatic reg_data_t isa_value(input instr_t w);
        reg_data_t  x;
        reg_data_t  y;
        logic [4:0] sh;
        logic       is_reg;
        if (w[6:0] == 7'b0110111) begin
            return {w[31:12], 12'h000};
        end
        is_reg = w[6:0] == 7'b0110011;
        x      = ref_regs[w[19:15]];
        y      = is_reg ? ref_regs[w[24:20]] : {{20{w[31]}}, w[31:20]};
        sh     = y[4:0];
        case (w[14:12])
            3'd0:    return (is_reg && w[30]) ? x - y : x + y;
            3'd1:    return x << sh;
            3'd2:    return ($signed(x) < $signed(y)) ? 32'd1 : 32'd0;
            3'd3:    return (x < y) ? 32'd1 : 32'd0;
            3'd4:    return x ^ y;
            3'd5:    return w[30] ? reg_data_t'($signed(x) >>> sh) : x >> sh;
            3'd6:    return x | y;
            default: return x & y;
        endcase
    endfunction

    // updates the model, queues the commit and puts the word on the bus
    task automatic present(input instr_t w);
        commit_t   exp;
        reg_data_t value;
        if (is_legal(w)) begin
            value    = isa_value(w);
            exp.rd   = w[11:7];
            exp.data = value;
            expected_q.push_back(exp);
            if (w[11:7] != 5'd0) begin
                ref_regs[w[11:7]] = value;
            end
        end
        instr_valid <= 1'b1;
        instr       <= w;
    endtask

    task automatic wait_accept(input int limit, output bit accepted);
        int waited;
        waited   = 0;
        accepted = 1'b0;
        while (!accepted && waited < limit) begin
            @(posedge clk);
            waited++;
            accepted = instr_ready; // transfer on this edge
        end
    endtask

    task automatic send(input instr_t w);
        bit ok;
        present(w);
        wait_accept(ACCEPT_LIMIT, ok);
        if (!ok) begin
            abort_timeout("instruction never accepted");
        end
    endtask

    task automatic idle();
        instr_valid <= 1'b0;
    endtask

    task automatic drain();
        int waited;
        waited = 0;
        while (expected_q.size() != 0 && waited < DRAIN_LIMIT) begin
            @(posedge clk);
            waited++;
        end
        if (expected_q.size() != 0) begin
            abort_timeout("expected commits never arrived");
        end
    endtask

    task automatic load_reg(input arf_id_t rd, input reg_data_t value);
        reg_data_t upper;
        upper = value + 32'h800; // compensates the sign of the addi immediate
        send(lui_word(upper[31:12], rd));
        send(i_type_word(value[11:0], rd, 3'b000, rd));
    endtask

    task automatic independent_ops_test();
        compare("commit_valid after reset", 32'(commit_valid), 32'd0);
        send(r_type_word(7'h00, 5'd2, 5'd1, 3'b000, 5'd3)); // reset registers read zero
        for (int i = 1; i < 6; i++) begin
            send(lui_word(20'($urandom()), arf_id_t'(i)));
            send(i_type_word(12'($urandom()), 5'd0, 3'b000, arf_id_t'(i + 8)));
        end
        idle();
        drain();
    endtask

    task automatic dependency_chain_test();
        logic [11:0] imm;
        send(i_type_word(12'($urandom()), 5'd0, 3'b000, 5'd6));
        for (int i = 0; i < 6; i++) begin
            imm = 12'($urandom());
            send(i_type_word(imm, 5'd6, 3'b100, 5'd7));       // xori
            send(r_type_word(7'h00, 5'd7, 5'd6, 3'b000, 5'd6)); // add
            send(r_type_word(7'h20, 5'd6, 5'd7, 3'b000, 5'd7)); // sub
            send(r_type_word(7'h00, 5'd7, 5'd6, 3'b001, 5'd6)); // sll
        end
        idle();
        drain();
    endtask

    task automatic all_alu_ops_test(input int rounds);
        reg_data_t   va;
        reg_data_t   vb;
        logic [11:0] imm;
        for (int r = 0; r < rounds; r++) begin
            va = $urandom();
            vb = $urandom();
            if (r == 0) begin
                vb = va; // equal operands for the compares
            end
            if (r == 1) begin
                va[31] = 1'b1;  // signed and unsigned compares disagree
                vb[31] = 1'b0;
            end
            load_reg(5'd10, va);
            load_reg(5'd11, vb);
            for (int f = 0; f < 8; f++) begin
                send(r_type_word(7'h00, 5'd11, 5'd10, 3'(f), arf_id_t'(12 + f)));
            end
            send(r_type_word(7'h20, 5'd11, 5'd10, 3'b000, 5'd20)); // sub
            send(r_type_word(7'h20, 5'd11, 5'd10, 3'b101, 5'd21)); // sra
            for (int f = 0; f < 8; f++) begin
                imm = 12'($urandom());
                if (f == 1 || f == 5) begin
                    imm = {7'h00, imm[4:0]}; // slli and srli carry a plain shamt
                end
                send(i_type_word(imm, 5'd10, 3'(f), arf_id_t'(22 + f)));
            end
            send(i_type_word({7'h20, 5'($urandom())}, 5'd10, 3'b101, 5'd30)); // srai
            send(lui_word(20'($urandom()), 5'd31));
            idle();
            drain();
        end
    endtask

    task automatic backpressure_test();
        int  accepted_n;
        bit  ok;
        bit  late_ok;
        accepted_n   = 0;
        ok           = 1'b1;
        commit_ready <= 1'b0;
        while (ok && accepted_n < 16) begin
            present(i_type_word(12'($urandom()), 5'd0, 3'b000, arf_id_t'(16 + accepted_n % 8)));
            wait_accept(STALL_LIMIT, ok);
            if (ok) begin
                accepted_n++;
            end
        end
        compare("instr_ready low with commit blocked", 32'(ok), 32'd0);
        compare("accepted at least rob depth", 32'(accepted_n >= ROB_DEPTH), 32'd1);
        compare("accepted at most rob plus execute", 32'(accepted_n <= ROB_DEPTH + 2), 32'd1);
        commit_ready <= 1'b1;
        if (!ok) begin
            wait_accept(ACCEPT_LIMIT, late_ok); // held word goes in after release
            if (!late_ok) begin
                abort_timeout("held instruction not accepted after release");
            end
        end
        send(r_type_word(7'h00, 5'd17, 5'd16, 3'b000, 5'd24)); // sources may still sit in the rob
        send(r_type_word(7'h00, 5'd19, 5'd18, 3'b100, 5'd25));
        send(r_type_word(7'h20, 5'd24, 5'd25, 3'b000, 5'd26));
        idle();
        drain();
    endtask

    task automatic illegal_opcode_test();
        send(i_type_word(12'h055, 5'd0, 3'b000, 5'd1));
        send(32'h0000_0083);                                // load opcode with rd x1
        send(32'hffff_ffff);
        send(r_type_word(7'h00, 5'd1, 5'd1, 3'b000, 5'd2)); // sees the addi only
        send(i_type_word(12'h7ff, 5'd1, 3'b110, 5'd3));
        idle();
        drain();
    endtask

    task automatic x0_write_test();
        send(i_type_word(12'h123, 5'd0, 3'b000, 5'd0)); // value still commits
        send(lui_word(20'habcde, 5'd0));
        send(r_type_word(7'h00, 5'd0, 5'd0, 3'b000, 5'd8));
        send(i_type_word(12'h005, 5'd0, 3'b110, 5'd9));
        send(r_type_word(7'h20, 5'd0, 5'd9, 3'b000, 5'd10));
        idle();
        drain();
    endtask

    // commit monitor pops one expected entry per transfer
    always @(posedge clk) begin
        commit_t exp;
        if (!reset && commit_valid && commit_ready) begin
            if (expected_q.size() == 0) begin
                errors++;
                $display("unexpected commit at %0t for rd %0d", $time, commit.rd);
            end else begin
                exp = expected_q.pop_front();
                compare("commit rd", 32'(commit.rd), 32'(exp.rd));
                compare("commit data", commit.data, exp.data);
            end
        end
    end

    initial begin
        void'($urandom(32'hc6c41db7));
        reset        = 1'b1;
        instr_valid  = 1'b0;
        instr        = '0;
        commit_ready = 1'b1;
        for (int i = 0; i < 32; i++) begin
            ref_regs[i] = '0;
        end
        repeat (5) @(posedge clk);
        reset <= 1'b0;
        @(posedge clk);
        independent_ops_test();
        dependency_chain_test();
        all_alu_ops_test(6);
        backpressure_test();
        illegal_opcode_test();
        x0_write_test();
        repeat (10) @(posedge clk); // stray commits would show up in this quiet period
        finish_run();
    end

endmodule

//--- design/core_top.sv
`timescale 1ns/1ps

module core_top import core_pkg::*; (
    input  logic    clk,
    input  logic    reset,
    input  logic    instr_valid,
    output logic    instr_ready,
    input  instr_t  instr,
    output logic    commit_valid,
    input  logic    commit_ready,
    output commit_t commit
);

    decoded_t  dec;
    exec_req_t exec_req;
    wb_t       wb;
    retire_t   retire;
    logic      alloc_valid, alloc_ready;
    arf_id_t   alloc_rd;
    rob_id_t   alloc_id;
    rob_id_t   src1_tag, src2_tag;
    logic      src1_done, src2_done;
    reg_data_t src1_data, src2_data;

    decode u_decode (
        .instr (instr),
        .dec   (dec)
    );

    dispatch u_dispatch (
        .clk         (clk),
        .reset       (reset),
        .instr_valid (instr_valid),
        .instr_ready (instr_ready),
        .dec         (dec),
        .alloc_valid (alloc_valid),
        .alloc_rd    (alloc_rd),
        .alloc_ready (alloc_ready),
        .alloc_id    (alloc_id),
        .src1_tag    (src1_tag),
        .src2_tag    (src2_tag),
        .src1_done   (src1_done),
        .src2_done   (src2_done),
        .src1_data   (src1_data),
        .src2_data   (src2_data),
        .wb          (wb),
        .retire      (retire),
        .exec_req    (exec_req)
    );

    alu_execute u_alu_execute (
        .clk   (clk),
        .reset (reset),
        .req   (exec_req),
        .wb    (wb)          // also feeds the dispatch bypass
    );

    rob u_rob (
        .clk          (clk),
        .reset        (reset),
        .alloc_valid  (alloc_valid),
        .alloc_rd     (alloc_rd),
        .alloc_ready  (alloc_ready),
        .alloc_id     (alloc_id),
        .src1_tag     (src1_tag),
        .src2_tag     (src2_tag),
        .src1_done    (src1_done),
        .src2_done    (src2_done),
        .src1_data    (src1_data),
        .src2_data    (src2_data),
        .wb           (wb),
        .retire       (retire),
        .commit_valid (commit_valid),
        .commit       (commit),
        .commit_ready (commit_ready)
    );

endmodule

//--- design/rob.sv
`timescale 1ns/1ps

module rob import core_pkg::*; (
    input  logic      clk,
    input  logic      reset,
    input  logic      alloc_valid,
    input  arf_id_t   alloc_rd,
    output logic      alloc_ready,
    output rob_id_t   alloc_id,
    input  rob_id_t   src1_tag,
    input  rob_id_t   src2_tag,
    output logic      src1_done,
    output logic      src2_done,
    output reg_data_t src1_data,
    output reg_data_t src2_data,
    input  wb_t       wb,
    output retire_t   retire,
    output logic      commit_valid,
    output commit_t   commit,
    input  logic      commit_ready
);

    arf_id_t              rd_q   [ROB_DEPTH];
    reg_data_t            data_q [ROB_DEPTH];
    logic [ROB_DEPTH-1:0] done_q;

    rob_id_t             head, tail;
    logic [ROB_ID_WIDTH:0] count;    // one extra bit to tell full from empty
    logic                do_retire;
    rob_id_t             wb_offset;

    assign alloc_ready = count != ROB_DEPTH;
    assign alloc_id    = tail;

    // source lookups for dispatch
    assign src1_done = done_q[src1_tag];
    assign src2_done = done_q[src2_tag];
    assign src1_data = data_q[src1_tag];
    assign src2_data = data_q[src2_tag];

    assign commit_valid = (count != '0) && done_q[head];
    assign commit       = '{rd: rd_q[head], data: data_q[head]};
    assign do_retire    = commit_valid && commit_ready; // retire only on the commit transfer

    assign retire = '{valid: do_retire, rob_id: head, rd: rd_q[head], data: data_q[head]};

    always_ff @(posedge clk) begin
        if (reset) begin
            head   <= '0;
            tail   <= '0;
            count  <= '0;
            done_q <= '0;
        end else begin
            if (alloc_valid) begin
                done_q[tail] <= 1'b0;
                tail         <= tail + 1'b1; // depth is a power of two, wraps for free
            end
            if (wb.valid) begin
                done_q[wb.rob_id] <= 1'b1;
            end
            if (do_retire) begin
                head <= head + 1'b1;
            end
            count <= count + (ROB_ID_WIDTH+1)'(alloc_valid) - (ROB_ID_WIDTH+1)'(do_retire);
        end
    end

    always_ff @(posedge clk) begin
        if (alloc_valid) begin
            rd_q[tail] <= alloc_rd;
        end
        if (wb.valid) begin
            data_q[wb.rob_id] <= wb.data;
        end
    end

    assign wb_offset = wb.rob_id - head; // distance from the oldest entry

    a_wb_to_live_entry: assert property (@(posedge clk) disable iff (reset)
        wb.valid |-> ({1'b0, wb_offset} < count) && !done_q[wb.rob_id]);

    a_commit_stable: assert property (@(posedge clk) disable iff (reset)
        commit_valid && !commit_ready |=> commit_valid && $stable(commit));

endmodule

//--- design/alu_execute.sv
`timescale 1ns/1ps

module alu_execute import core_pkg::*; (
    input  logic      clk,
    input  logic      reset,
    input  exec_req_t req,
    output wb_t       wb
);

    exec_req_t  req_q;
    reg_data_t  result;
    logic [4:0] shamt;

    assign shamt = req_q.b[4:0]; // rv32 shifts use the low 5 bits only

    always_comb begin
        case (req_q.op)
            ALU_ADD:    result = req_q.a + req_q.b;
            ALU_SUB:    result = req_q.a - req_q.b;
            ALU_SLL:    result = req_q.a << shamt;
            ALU_SLT:    result = {{(XLEN-1){1'b0}}, $signed(req_q.a) < $signed(req_q.b)};
            ALU_SLTU:   result = {{(XLEN-1){1'b0}}, req_q.a < req_q.b};
            ALU_XOR:    result = req_q.a ^ req_q.b;
            ALU_SRL:    result = req_q.a >> shamt;
            ALU_SRA:    result = reg_data_t'($signed(req_q.a) >>> shamt);
            ALU_OR:     result = req_q.a | req_q.b;
            ALU_AND:    result = req_q.a & req_q.b;
            ALU_PASS_B: result = req_q.b;
            default:    result = '0;
        endcase
    end

    // stage 1 holds the request, stage 2 the tagged result
    always_ff @(posedge clk) begin
        if (reset) begin
            req_q.valid <= 1'b0;
            wb.valid    <= 1'b0;
        end else begin
            req_q <= req;
            wb    <= '{valid: req_q.valid, rob_id: req_q.rob_id, data: result};
        end
    end

endmodule

//--- design/dispatch.sv
`timescale 1ns/1ps

module dispatch import core_pkg::*; (
    input  logic      clk,
    input  logic      reset,
    input  logic      instr_valid,
    output logic      instr_ready,
    input  decoded_t  dec,
    output logic      alloc_valid,
    output arf_id_t   alloc_rd,
    input  logic      alloc_ready,
    input  rob_id_t   alloc_id,
    output rob_id_t   src1_tag,
    output rob_id_t   src2_tag,
    input  logic      src1_done,
    input  logic      src2_done,
    input  reg_data_t src1_data,
    input  reg_data_t src2_data,
    input  wb_t       wb,
    input  retire_t   retire,
    output exec_req_t exec_req
);

    logic [ARF_N_ENTRIES-1:0] busy;                 // 1 = value lives in the rob
    rob_id_t                  tag_table [ARF_N_ENTRIES];
    reg_data_t                arf       [ARF_N_ENTRIES];

    logic      rs1_busy, rs2_busy;
    logic      src1_hit, src2_hit;
    logic      src1_avail, src2_avail;
    logic      accept, rename_rd;
    logic      retire_wr, retire_match;
    reg_data_t opnd_a, rs2_val;

    // rename lookup
    assign rs1_busy = dec.rs1_exists && busy[dec.rs1];
    assign rs2_busy = dec.rs2_exists && busy[dec.rs2];
    assign src1_tag = tag_table[dec.rs1];
    assign src2_tag = tag_table[dec.rs2];

    // writeback bypass catches a result in the cycle it leaves the alu
    assign src1_hit = wb.valid && (wb.rob_id == src1_tag);
    assign src2_hit = wb.valid && (wb.rob_id == src2_tag);

    assign src1_avail = !rs1_busy || src1_done || src1_hit;
    assign src2_avail = !rs2_busy || src2_done || src2_hit;

    assign opnd_a  = !rs1_busy ? arf[dec.rs1] : src1_hit ? wb.data : src1_data;
    assign rs2_val = !rs2_busy ? arf[dec.rs2] : src2_hit ? wb.data : src2_data;

    // illegal words are swallowed without a rob slot
    assign instr_ready = dec.illegal || (alloc_ready && src1_avail && src2_avail);
    assign accept      = instr_valid && instr_ready;
    assign alloc_valid = accept && !dec.illegal;
    assign alloc_rd    = dec.rd;
    assign rename_rd   = alloc_valid && (dec.rd != '0); // x0 is never renamed

    assign exec_req = '{
        valid:  alloc_valid,
        rob_id: alloc_id,
        op:     dec.op,
        a:      opnd_a,
        b:      dec.use_imm ? dec.imm : rs2_val
    };

    assign retire_wr    = retire.valid && (retire.rd != '0);
    assign retire_match = tag_table[retire.rd] == retire.rob_id;

    always_ff @(posedge clk) begin
        if (reset) begin
            busy <= '0;
            for (int i = 0; i < ARF_N_ENTRIES; i++) begin
                arf[i] <= '0;
            end
        end else begin
            if (retire_wr) begin
                arf[retire.rd] <= retire.data;
                if (retire_match) begin
                    busy[retire.rd] <= 1'b0; // no younger writer in flight
                end
            end
            if (rename_rd) begin
                busy[dec.rd] <= 1'b1; // a new rename wins over a same-cycle retire
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rename_rd) begin
            tag_table[dec.rd] <= alloc_id;
        end
    end

    a_alloc_needs_room: assert property (@(posedge clk) disable iff (reset)
        alloc_valid |-> alloc_ready);

    // a retire that still owns the alias must find the register busy
    a_retire_owner_busy: assert property (@(posedge clk) disable iff (reset)
        retire_wr && retire_match |-> busy[retire.rd]);

endmodule

//--- design/decode.sv
`timescale 1ns/1ps

module decode import core_pkg::*; (
    input  instr_t   instr,
    output decoded_t dec
);

    opcode_e    opcode;
    logic [2:0] funct3;
    logic       alt;     // funct7 bit 5, selects sub and sra

    assign opcode = opcode_e'(instr[6:0]);
    assign funct3 = instr[14:12];
    assign alt    = instr[30];

    // sub only exists in the register form, srai shares the alt bit with sra
    function automatic alu_op_e alu_fn(
        input logic [2:0] f3,
        input logic       alt_bit,
        input logic       is_reg
    );
        alu_op_e op;
        case (f3)
            3'b000:  op = (is_reg && alt_bit) ? ALU_SUB : ALU_ADD;
            3'b001:  op = ALU_SLL;
            3'b010:  op = ALU_SLT;
            3'b011:  op = ALU_SLTU;
            3'b100:  op = ALU_XOR;
            3'b101:  op = alt_bit ? ALU_SRA : ALU_SRL;
            3'b110:  op = ALU_OR;
            default: op = ALU_AND;
        endcase
        return op;
    endfunction

    always_comb begin
        dec     = '0;
        dec.rs1 = instr[19:15];
        dec.rs2 = instr[24:20];
        dec.rd  = instr[11:7];
        case (opcode)
            OP: begin
                dec.rs1_exists = 1'b1;
                dec.rs2_exists = 1'b1;
                dec.op         = alu_fn(funct3, alt, 1'b1);
            end
            OP_IMM: begin
                dec.rs1_exists = 1'b1;
                dec.use_imm    = 1'b1;
                dec.imm        = {{20{instr[31]}}, instr[31:20]}; // I-immediate
                dec.op         = alu_fn(funct3, alt, 1'b0);
            end
            LUI: begin
                dec.use_imm = 1'b1;
                dec.imm     = {instr[31:12], 12'b0}; // U-immediate
                dec.op      = ALU_PASS_B;
            end
            default: begin
                dec.illegal = 1'b1;
            end
        endcase
    end

endmodule

//--- design/core_pkg.sv
package core_pkg;

    localparam int XLEN          = 32;
    localparam int ROB_DEPTH     = 8;
    localparam int ROB_ID_WIDTH  = 3;
    localparam int ARF_N_ENTRIES = 32;

    typedef logic [XLEN-1:0]         reg_data_t;
    typedef logic [31:0]             instr_t;
    typedef logic [4:0]              arf_id_t;
    typedef logic [ROB_ID_WIDTH-1:0] rob_id_t;

    // RV32I major opcodes handled by this slice, anything else is illegal
    typedef enum logic [6:0] {
        OP     = 7'b0110011,
        OP_IMM = 7'b0010011,
        LUI    = 7'b0110111
    } opcode_e;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_SLL,
        ALU_SLT,
        ALU_SLTU,
        ALU_XOR,
        ALU_SRL,
        ALU_SRA,
        ALU_OR,
        ALU_AND,
        ALU_PASS_B // lui, result is operand b
    } alu_op_e;

    typedef struct packed {
        logic      rs1_exists;
        arf_id_t   rs1;
        logic      rs2_exists;
        arf_id_t   rs2;
        arf_id_t   rd;
        reg_data_t imm;
        logic      use_imm;    // operand b comes from imm
        alu_op_e   op;
        logic      illegal;
    } decoded_t;

    typedef struct packed {
        logic      valid;
        rob_id_t   rob_id;
        alu_op_e   op;
        reg_data_t a;
        reg_data_t b;
    } exec_req_t;

    typedef struct packed {
        logic      valid;
        rob_id_t   rob_id;
        reg_data_t data;
    } wb_t;

    typedef struct packed {
        logic      valid;
        rob_id_t   rob_id;
        arf_id_t   rd;
        reg_data_t data;
    } retire_t;

    typedef struct packed {
        arf_id_t   rd;
        reg_data_t data;
    } commit_t;

endpackage
